/* hw/fetch_pkg.sv */
package fetch_pkg;

    // Machine word for addresses, instructions and trap causes
    typedef logic [31:0] xlen_t;

    // Level-valued response from the instruction cache
    typedef enum logic [2:0] {
        resp_idle         = 3'd0,
        resp_wait         = 3'd1,
        resp_done         = 3'd2,
        resp_access_fault = 3'd3,
        resp_misaligned   = 3'd4,
        resp_page_fault   = 3'd5
    } cache_resp_e;

    // Command strobe towards the cache
    typedef enum logic [1:0] {
        cmd_none      = 2'd0,
        cmd_execute   = 2'd1,
        cmd_flush_all = 2'd2
    } cache_cmd_e;

    typedef enum logic [1:0] {
        e2f_cmd_none     = 2'd0,
        e2f_bubble_jump  = 2'd1,
        e2f_flush        = 2'd2,
        e2f_branch_taken = 2'd3
    } e2f_cmd_e;

    // RISC-V privilege encoding with 2'b10 reserved
    typedef enum logic [1:0] {
        priv_user       = 2'b00,
        priv_supervisor = 2'b01,
        priv_machine    = 2'b11
    } priv_e;

    typedef enum logic [1:0] {
        trap_none      = 2'd0,
        trap_interrupt = 2'd1,
        trap_fault     = 2'd2
    } trap_kind_e;

    // Request coming back from execute
    typedef struct packed {
        logic     ready;
        e2f_cmd_e cmd;
        xlen_t    jump_target;
        xlen_t    branch_target;
    } e2f_s;

    // CSR values needed for trap routing
    typedef struct packed {
        xlen_t       mtvec;
        xlen_t       stvec;
        priv_e       current_privilege;
        logic [15:0] medeleg;
    } trap_csr_s;

    typedef struct packed {
        logic  pending;
        xlen_t cause;
        xlen_t target_pc;
        priv_e target_privilege;
    } irq_s;

    // Trap decision from the router
    typedef struct packed {
        trap_kind_e kind;
        xlen_t      cause;
        priv_e      privilege;
        xlen_t      target_pc;
    } trap_info_s;

    // Instruction and exception report towards execute
    typedef struct packed {
        logic  ignore;
        xlen_t instr;
        xlen_t pc;
        logic  exc_start;
        xlen_t epc;
        xlen_t cause;
        priv_e exc_privilege;
    } f2e_s;

    localparam xlen_t reset_vector = 32'h0000_2000;

    // Instruction fetch exception codes
    localparam xlen_t exc_instr_misaligned   = 32'd0;
    localparam xlen_t exc_instr_access_fault = 32'd1;
    localparam xlen_t exc_instr_page_fault   = 32'd12;

endpackage

/* hw/fetch_sequencer.sv */
`timescale 1ns/1ps

module fetch_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   c_reset_done,
    input  fetch_pkg::cache_resp_e c_response,
    input  fetch_pkg::e2f_s        e2f,
    input  fetch_pkg::trap_info_s  trap,
    output fetch_pkg::cache_cmd_e  c_cmd,
    output fetch_pkg::xlen_t       c_address,
    output fetch_pkg::xlen_t       pc,
    output logic                   bubble,
    output logic                   flushing,
    output logic                   trap_take,
    output logic                   instret_incr
);
    import fetch_pkg::*;

    xlen_t pc_nxt;
    logic  bubble_nxt;
    logic  flushing_nxt;

    logic  cache_done;
    logic  cache_idle;
    logic  cache_error;
    logic  new_fetch;
    xlen_t pc_plus_4;

    assign cache_done  = (c_response == resp_done);
    assign cache_idle  = (c_response == resp_idle);
    assign cache_error = (c_response == resp_access_fault) ||
                         (c_response == resp_misaligned) ||
                         (c_response == resp_page_fault);

    // Execute can take the next instruction and the cache is not busy
    assign new_fetch = e2f.ready && (cache_done || cache_idle || cache_error);

    assign pc_plus_4 = pc + 32'd4;

    // Cache sees the upcoming PC in the same cycle as the command
    assign c_address = pc_nxt;

    always_comb begin
        pc_nxt       = pc;
        bubble_nxt   = bubble;
        flushing_nxt = flushing;
        c_cmd        = cmd_none;
        instret_incr = 1'b0;
        trap_take    = 1'b0;

        if (rst_n && c_reset_done) begin
            if (flushing) begin
                // Keep flushing until the cache reports completion
                if (cache_done) begin
                    flushing_nxt = 1'b0;
                end else begin
                    c_cmd = cmd_flush_all;
                end
            end else if (bubble && cache_idle && e2f.ready) begin
                // Refill from the current PC
                c_cmd      = cmd_execute;
                bubble_nxt = 1'b0;
            end else if (new_fetch) begin
                instret_incr = 1'b1;
                if (trap.kind == trap_interrupt) begin
                    bubble_nxt = 1'b1;
                    pc_nxt     = trap.target_pc;
                    trap_take  = 1'b1;
                end else if (e2f.cmd == e2f_bubble_jump) begin
                    bubble_nxt = 1'b1;
                    pc_nxt     = e2f.jump_target;
                end else if (e2f.cmd == e2f_flush) begin
                    // Flush starts next cycle and then refills at pc+4
                    bubble_nxt   = 1'b1;
                    flushing_nxt = 1'b1;
                    pc_nxt       = pc_plus_4;
                end else if (e2f.cmd == e2f_branch_taken) begin
                    pc_nxt = e2f.branch_target;
                    c_cmd  = cmd_execute;
                end else if (trap.kind == trap_fault) begin
                    bubble_nxt = 1'b1;
                    pc_nxt     = trap.target_pc;
                    trap_take  = 1'b1;
                end else begin
                    pc_nxt = pc_plus_4;
                    c_cmd  = cmd_execute;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= reset_vector;
            bubble   <= 1'b1;
            flushing <= 1'b0;
        end else if (c_reset_done) begin
            pc       <= pc_nxt;
            bubble   <= bubble_nxt;
            flushing <= flushing_nxt;
        end
    end

    // A flush always leaves a bubble pending for the refill
    a_flush_needs_flushing: assert property (
        @(posedge clk) disable iff (!rst_n)
        (c_cmd == cmd_flush_all) |-> (flushing && bubble)
    );

    // Taken trap lands on its target with a bubble pending
    a_trap_take_has_kind: assert property (
        @(posedge clk) disable iff (!rst_n)
        trap_take |=> (bubble && (pc == $past(trap.target_pc)))
    );

endmodule

/* hw/fetch_trap_router.sv */
`timescale 1ns/1ps

module fetch_trap_router (
    input  fetch_pkg::cache_resp_e c_response,
    input  fetch_pkg::trap_csr_s   csr,
    input  fetch_pkg::irq_s        irq,
    output fetch_pkg::trap_info_s  trap
);
    import fetch_pkg::*;

    logic  is_fault;
    xlen_t fault_cause;
    logic  delegated;

    // Map the cache error response to its exception code
    always_comb begin
        is_fault    = 1'b1;
        fault_cause = exc_instr_access_fault;
        case (c_response)
            resp_misaligned:   fault_cause = exc_instr_misaligned;
            resp_access_fault: fault_cause = exc_instr_access_fault;
            resp_page_fault:   fault_cause = exc_instr_page_fault;
            default:           is_fault    = 1'b0;
        endcase
    end

    // Machine mode traps are never delegated
    assign delegated = (csr.current_privilege != priv_machine) &&
                       csr.medeleg[fault_cause[3:0]];

    always_comb begin
        trap = '{kind: trap_none, cause: '0, privilege: priv_user, target_pc: '0};
        if (irq.pending) begin
            trap.kind      = trap_interrupt;
            trap.cause     = irq.cause;
            trap.privilege = irq.target_privilege;
            trap.target_pc = irq.target_pc;
        end else if (is_fault) begin
            trap.kind  = trap_fault;
            trap.cause = fault_cause;
            if (delegated) begin
                trap.privilege = priv_supervisor;
                trap.target_pc = csr.stvec;
            end else begin
                trap.privilege = priv_machine;
                trap.target_pc = csr.mtvec;
            end
        end
    end

endmodule

/* hw/fetch_issue.sv */
`timescale 1ns/1ps

module fetch_issue (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   c_reset_done,
    input  fetch_pkg::cache_resp_e c_response,
    input  fetch_pkg::xlen_t       c_load_data,
    input  fetch_pkg::xlen_t       pc,
    input  logic                   bubble,
    input  logic                   flushing,
    input  logic                   trap_take,
    input  fetch_pkg::trap_info_s  trap,
    output fetch_pkg::f2e_s        f2e
);
    import fetch_pkg::*;

    xlen_t saved_instr;
    xlen_t instr;
    logic  ignore;

    logic  exc_start_q;
    xlen_t epc_q;
    xlen_t cause_q;
    priv_e exc_priv_q;

    // Instruction or bubble towards execute
    always_comb begin
        instr  = c_load_data;
        ignore = 1'b1;
        if (c_reset_done) begin
            if (c_response == resp_done && !flushing) begin
                ignore = 1'b0;
            end else if (c_response == resp_idle && !bubble) begin
                // Repeat last instruction while the cache sits idle
                instr  = saved_instr;
                ignore = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (c_reset_done && c_response == resp_done && !flushing) begin
            saved_instr <= c_load_data;
        end
    end

    // Exception report is a single-cycle pulse after trap_take
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exc_start_q <= 1'b0;
        end else if (c_reset_done) begin
            exc_start_q <= trap_take;
        end
    end

    always_ff @(posedge clk) begin
        if (c_reset_done) begin
            epc_q      <= trap_take ? pc : '0;
            cause_q    <= trap_take ? trap.cause : '0;
            exc_priv_q <= trap_take ? trap.privilege : priv_user;
        end
    end

    always_comb begin
        f2e.ignore        = ignore;
        f2e.instr         = instr;
        f2e.pc            = pc;
        f2e.exc_start     = exc_start_q;
        f2e.epc           = epc_q;
        f2e.cause         = cause_q;
        f2e.exc_privilege = exc_priv_q;
    end

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // Instruction cache
    input  fetch_pkg::cache_resp_e c_response,
    input  logic                   c_reset_done,
    input  fetch_pkg::xlen_t       c_load_data,
    output fetch_pkg::cache_cmd_e  c_cmd,
    output fetch_pkg::xlen_t       c_address,
    // Trap setup and interrupts
    input  fetch_pkg::trap_csr_s   csr,
    input  fetch_pkg::irq_s        irq,
    // Execute stage
    input  fetch_pkg::e2f_s        e2f,
    output fetch_pkg::f2e_s        f2e,
    output logic                   instret_incr
);
    import fetch_pkg::*;

    trap_info_s trap;
    xlen_t      pc;
    logic       bubble;
    logic       flushing;
    logic       trap_take;

    fetch_sequencer fetch_sequencer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .c_reset_done (c_reset_done),
        .c_response   (c_response),
        .e2f          (e2f),
        .trap         (trap),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .pc           (pc),
        .bubble       (bubble),
        .flushing     (flushing),
        .trap_take    (trap_take),
        .instret_incr (instret_incr)
    );

    fetch_trap_router fetch_trap_router_i (
        .c_response (c_response),
        .csr        (csr),
        .irq        (irq),
        .trap       (trap)
    );

    fetch_issue fetch_issue_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .c_reset_done (c_reset_done),
        .c_response   (c_response),
        .c_load_data  (c_load_data),
        .pc           (pc),
        .bubble       (bubble),
        .flushing     (flushing),
        .trap_take    (trap_take),
        .trap         (trap),
        .f2e          (f2e)
    );

endmodule

/* verif/fetch_tb_vectors.svh */
`ifndef FETCH_TB_VECTORS_SVH
`define FETCH_TB_VECTORS_SVH

// Stimulus columns are response, load data, ready, e2f cmd, target, irq pending and user mode
// Then expected c_cmd, c_address, instret_incr, ignore, instr and next-cycle trap report
localparam int num_rows = 21;

vec_s vectors [num_rows] = '{
    // Refill after reset and two deliveries
    '{resp_idle, 'h0, 1, e2f_cmd_none, 'h0, 0, 0, cmd_execute, 'h2000, 0, 1, 'h0, 0},
    '{resp_done, 'ha00093, 1, e2f_cmd_none, 'h0, 0, 0, cmd_execute, 'h2004, 1, 0, 'ha00093, 0},
    '{resp_done, 'h100113, 1, e2f_cmd_none, 'h0, 0, 0, cmd_execute, 'h2008, 1, 0, 'h100113, 0},
    // Execute stalls, saved instruction stays visible
    '{resp_idle, 'hdeadbeef, 0, e2f_cmd_none, 'h0, 0, 0, cmd_none, 'h2008, 0, 0, 'h100113, 0},
    '{resp_idle, 'hdeadbeef, 0, e2f_cmd_none, 'h0, 0, 0, cmd_none, 'h2008, 0, 0, 'h100113, 0},
    '{resp_idle, 'h0, 1, e2f_branch_taken, 'h3000, 0, 0, cmd_execute, 'h3000, 1, 0, 'h100113, 0},
    '{resp_done, 'h300213, 1, e2f_bubble_jump, 'h4000, 0, 0, cmd_none, 'h4000, 1, 0, 'h300213, 0},
    '{resp_idle, 'h0, 0, e2f_cmd_none, 'h0, 0, 0, cmd_none, 'h4000, 0, 1, 'h0, 0},
    '{resp_idle, 'h0, 1, e2f_cmd_none, 'h0, 0, 0, cmd_execute, 'h4000, 0, 1, 'h0, 0},
    // Flush with two wait cycles
    '{resp_done, 'h400293, 1, e2f_flush, 'h0, 0, 0, cmd_none, 'h4004, 1, 0, 'h400293, 0},
    '{resp_wait, 'h0, 1, e2f_cmd_none, 'h0, 0, 0, cmd_flush_all, 'h4004, 0, 1, 'h0, 0},
    '{resp_wait, 'h0, 1, e2f_cmd_none, 'h0, 0, 0, cmd_flush_all, 'h4004, 0, 1, 'h0, 0},
    '{resp_done, 'h11111111, 1, e2f_cmd_none, 'h0, 0, 0, cmd_none, 'h4004, 0, 1, 'h0, 0},
    '{resp_idle, 'h0, 1, e2f_cmd_none, 'h0, 0, 0, cmd_execute, 'h4004, 0, 1, 'h0, 0},
    // Page fault delegated from user mode and one taken in machine mode
    '{resp_page_fault, 'h0, 1, e2f_cmd_none, 'h0, 0, 1, cmd_none, 'h200, 1, 1, 'h0, 1},
    '{resp_idle, 'h0, 1, e2f_cmd_none, 'h0, 0, 1, cmd_execute, 'h200, 0, 1, 'h0, 0},
    '{resp_page_fault, 'h0, 1, e2f_cmd_none, 'h0, 0, 0, cmd_none, 'h100, 1, 1, 'h0, 1},
    '{resp_idle, 'h0, 1, e2f_cmd_none, 'h0, 0, 0, cmd_execute, 'h100, 0, 1, 'h0, 0},
    // Interrupt beats a taken branch
    '{resp_done, 'h500313, 1, e2f_branch_taken, 'h5000, 1, 0, cmd_none, 'h300, 1, 0, 'h500313, 1},
    '{resp_idle, 'h0, 1, e2f_cmd_none, 'h0, 0, 0, cmd_execute, 'h300, 0, 1, 'h0, 0},
    '{resp_done, 'h600393, 1, e2f_cmd_none, 'h0, 0, 0, cmd_execute, 'h304, 1, 0, 'h600393, 0}
};

// Trap reports as epc, cause and privilege in the order they are raised
exc_s exc_table [3] = '{
    '{'h4004, 'd12, priv_supervisor},
    '{'h200, 'd12, priv_machine},
    '{'h100, 'h8000000b, priv_machine}
};

`endif

/* verif/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    typedef struct packed {
        cache_resp_e resp;
        xlen_t       data;
        logic        ready;
        e2f_cmd_e    cmd;
        xlen_t       target;
        logic        irq;
        logic        user;
        cache_cmd_e  exp_cmd;
        xlen_t       exp_addr;
        logic        exp_incr;
        logic        exp_ign;
        xlen_t       exp_instr;
        logic        exp_exc;
    } vec_s;

    typedef struct packed {
        xlen_t epc;
        xlen_t cause;
        priv_e priv;
    } exc_s;

    `include "fetch_tb_vectors.svh"

    // Fixed interrupt source used by every row
    localparam xlen_t irq_cause  = 32'h8000_000b;
    localparam xlen_t irq_target = 32'h0000_0300;

    logic        clk;
    logic        rst_n;
    cache_resp_e c_response;
    logic        c_reset_done;
    xlen_t       c_load_data;
    cache_cmd_e  c_cmd;
    xlen_t       c_address;
    trap_csr_s   csr;
    irq_s        irq;
    e2f_s        e2f;
    f2e_s        f2e;
    logic        instret_incr;

    int    errors;
    int    checks;
    int    row;
    int    exc_idx;
    logic  exc_due;
    vec_s  v;
    f2e_s  exp_f2e;
    xlen_t exp_pc;

    fetch_top fetch_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .c_response   (c_response),
        .c_reset_done (c_reset_done),
        .c_load_data  (c_load_data),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .csr          (csr),
        .irq          (irq),
        .e2f          (e2f),
        .f2e          (f2e),
        .instret_incr (instret_incr)
    );

    always #10 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("Fail row %0d: %s expected 0x%h, got 0x%h", row, name, exp, act);
    endtask

    task automatic check_cmd(input cache_cmd_e exp, input cache_cmd_e act);
        checks++;
        if (act !== exp) report_mismatch("c_cmd", exp, act);
    endtask

    task automatic check_addr(input xlen_t exp, input xlen_t act);
        checks++;
        if (act !== exp) report_mismatch("c_address", exp, act);
    endtask

    task automatic check_incr(input logic exp, input logic act);
        checks++;
        if (act !== exp) report_mismatch("instret_incr", exp, act);
    endtask

    // Instr is only meaningful when no bubble is expected
    task automatic check_f2e(input f2e_s exp, input f2e_s act, input logic instr_defined);
        checks++;
        if (act.ignore !== exp.ignore) report_mismatch("f2e.ignore", exp.ignore, act.ignore);
        if (instr_defined && act.instr !== exp.instr) begin
            report_mismatch("f2e.instr", exp.instr, act.instr);
        end
        if (act.pc !== exp.pc) report_mismatch("f2e.pc", exp.pc, act.pc);
        if (act.exc_start !== exp.exc_start) begin
            report_mismatch("f2e.exc_start", exp.exc_start, act.exc_start);
        end
        if (act.epc !== exp.epc) report_mismatch("f2e.epc", exp.epc, act.epc);
        if (act.cause !== exp.cause) report_mismatch("f2e.cause", exp.cause, act.cause);
        if (act.exc_privilege !== exp.exc_privilege) begin
            report_mismatch("f2e.exc_privilege", exp.exc_privilege, act.exc_privilege);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        c_response   = resp_idle;
        c_reset_done = 1'b1;
        c_load_data  = '0;
        csr = '{mtvec: 32'h100, stvec: 32'h200, current_privilege: priv_machine,
                medeleg: 16'h1000};
        irq          = '0;
        e2f          = '0;
        errors       = 0;
        checks       = 0;
        exc_idx      = 0;
        exc_due      = 1'b0;
        exp_pc       = reset_vector;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        for (row = 0; row < num_rows; row++) begin
            v = vectors[row];
            @(posedge clk);
            c_response  <= v.resp;
            c_load_data <= v.data;
            // The target not selected by the command carries a different value
            e2f <= '{ready: v.ready, cmd: v.cmd,
                     jump_target: (v.cmd == e2f_bubble_jump) ? v.target : ~v.target,
                     branch_target: (v.cmd == e2f_branch_taken) ? v.target : ~v.target};
            irq <= '{pending: v.irq, cause: irq_cause, target_pc: irq_target,
                     target_privilege: priv_machine};
            csr.current_privilege <= v.user ? priv_user : priv_machine;

            @(negedge clk);
            check_cmd(v.exp_cmd, c_cmd);
            check_addr(v.exp_addr, c_address);
            check_incr(v.exp_incr, instret_incr);

            // Trap report from the previous row shows up now
            exp_f2e        = '0;
            exp_f2e.ignore = v.exp_ign;
            exp_f2e.instr  = v.exp_instr;
            exp_f2e.pc     = exp_pc;
            if (exc_due) begin
                exp_f2e.exc_start     = 1'b1;
                exp_f2e.epc           = exc_table[exc_idx].epc;
                exp_f2e.cause         = exc_table[exc_idx].cause;
                exp_f2e.exc_privilege = exc_table[exc_idx].priv;
                exc_idx++;
            end
            check_f2e(exp_f2e, f2e, !v.exp_ign);
            exc_due = v.exp_exc;
            // Next PC of this row becomes the current PC of the next one
            exp_pc  = v.exp_addr;
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Reset, every table row and some slack
    initial begin
        #((5 + num_rows + 20) * 20);
        $display("Timeout: the test did not reach its end in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verif
hw/fetch_pkg.sv
hw/fetch_sequencer.sv
hw/fetch_trap_router.sv
hw/fetch_issue.sv
hw/fetch_top.sv
verif/fetch_tb.sv
